// File: Makefile
VERILATOR ?= verilator
TOP       ?= rcc_ctrl_tb
FILELIST  ?= rcc_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/rcc_ctrl_tb.sv
`timescale 1ns/1ps

module rcc_ctrl_tb;

  import rcc_pkg::*;

  // expected timing, kept apart from the design constants
  localparam int SYS_RELEASE = 3;
  localparam int D1_STRETCH  = 10;
  localparam int D2_STRETCH  = 10;
  localparam int CLK_DELAY   = 8;

  localparam int SEL_SYS_RST = 0;
  localparam int SEL_D1_RST  = 1;
  localparam int SEL_D2_RST  = 2;
  localparam int SEL_SYS_EN  = 3;
  localparam int SEL_D1_REQ  = 4;
  localparam int SEL_D2_REQ  = 5;

  logic        clk;
  logic        rst_n;
  logic        nrst_pin;
  logic        pwr_por_rst;
  logic        pwr_bor_rst;
  logic        pwr_vcore_ok;
  logic        iwdg1_rst;
  logic        iwdg2_rst;
  logic        wwdg1_rst;
  logic        wwdg2_rst;
  logic        ww1rsc;
  logic        ww2rsc;
  logic [1:0]  lpwr_rst;
  logic [1:0]  sft_rst;
  logic        flash_obl_reload;
  logic        obl_done;
  logic        flash_power_ok;
  logic        hsi_rdy;
  logic        pwr_d1_ok;
  logic        pwr_d2_ok;
  logic        d3_deepsleep;
  logic        d1_wkup;
  logic        d2_wkup;
  logic        d3_wkup;
  logic        arcg_on;
  rcc_cpu_pm_t pm;
  rcc_busy_t   busy;
  rcc_alloc_t  c1_alloc;
  rcc_alloc_t  c2_alloc;
  logic        c2_alloc_d1;
  logic        c1_alloc_d2;
  rcc_rst_t    o_rst;
  rcc_clk_en_t o_clk_en;
  logic        o_d1_req;
  logic        o_d2_req;
  logic        o_d3_req;
  logic        o_obl_rst_n;
  logic        o_nrst_out;

  rcc_ctrl_top u_rcc_ctrl_top (
    .i_clk              (clk),
    .i_rst_n            (rst_n),
    .i_nrst_pin         (nrst_pin),
    .i_pwr_por_rst      (pwr_por_rst),
    .i_pwr_bor_rst      (pwr_bor_rst),
    .i_pwr_vcore_ok     (pwr_vcore_ok),
    .i_iwdg1_rst        (iwdg1_rst),
    .i_iwdg2_rst        (iwdg2_rst),
    .i_wwdg1_rst        (wwdg1_rst),
    .i_wwdg2_rst        (wwdg2_rst),
    .i_ww1rsc           (ww1rsc),
    .i_ww2rsc           (ww2rsc),
    .i_lpwr_rst         (lpwr_rst),
    .i_sft_rst          (sft_rst),
    .i_flash_obl_reload (flash_obl_reload),
    .i_obl_done         (obl_done),
    .i_flash_power_ok   (flash_power_ok),
    .i_hsi_rdy          (hsi_rdy),
    .i_pwr_d1_ok        (pwr_d1_ok),
    .i_pwr_d2_ok        (pwr_d2_ok),
    .i_d3_deepsleep     (d3_deepsleep),
    .i_d1_wkup          (d1_wkup),
    .i_d2_wkup          (d2_wkup),
    .i_d3_wkup          (d3_wkup),
    .i_arcg_on          (arcg_on),
    .i_pm               (pm),
    .i_busy             (busy),
    .i_c1_alloc         (c1_alloc),
    .i_c2_alloc         (c2_alloc),
    .i_c2_alloc_d1      (c2_alloc_d1),
    .i_c1_alloc_d2      (c1_alloc_d2),
    .o_rst              (o_rst),
    .o_clk_en           (o_clk_en),
    .o_d1_req           (o_d1_req),
    .o_d2_req           (o_d2_req),
    .o_d3_req           (o_d3_req),
    .o_obl_rst_n        (o_obl_rst_n),
    .o_nrst_out         (o_nrst_out)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // hard stop in case a test loop misbehaves
  initial begin
    #50000;
    $display("run exceeded its time limit");
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on global timeout");
  end

  // ====================================================================
  // helpers
  // ====================================================================
  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // lets combinational outputs follow a new input
  task automatic settle();
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_SYS_RST: probe = o_rst.sys;
      SEL_D1_RST:  probe = o_rst.d1;
      SEL_D2_RST:  probe = o_rst.d2;
      SEL_SYS_EN:  probe = o_clk_en.sys;
      SEL_D1_REQ:  probe = o_d1_req;
      SEL_D2_REQ:  probe = o_d2_req;
      default:     probe = 1'bx;
    endcase
  endfunction

  // counts rising edges until the selected output reaches the level
  task automatic wait_for(input string what, input int sel, input logic level,
                          input int limit, output int n);
    n = 0;
    while (probe(sel) !== level) begin
      if (n >= limit) begin
        $display("timeout after %0d cycles waiting for %s", n, what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on timeout");
      end
      tick();
      n++;
    end
  endtask

  task automatic drive_defaults();
    rst_n            = 1'b0;
    nrst_pin         = 1'b1;
    pwr_por_rst      = 1'b0;
    pwr_bor_rst      = 1'b0;
    pwr_vcore_ok     = 1'b1;
    iwdg1_rst        = 1'b0;
    iwdg2_rst        = 1'b0;
    wwdg1_rst        = 1'b0;
    wwdg2_rst        = 1'b0;
    ww1rsc           = 1'b0;
    ww2rsc           = 1'b0;
    lpwr_rst         = '0;
    sft_rst          = '0;
    flash_obl_reload = 1'b0;
    obl_done         = 1'b1;
    flash_power_ok   = 1'b0;
    hsi_rdy          = 1'b0;
    pwr_d1_ok        = 1'b0;
    pwr_d2_ok        = 1'b0;
    d3_deepsleep     = 1'b0;
    d1_wkup          = 1'b0;
    d2_wkup          = 1'b0;
    d3_wkup          = 1'b0;
    arcg_on          = 1'b1;
    pm               = '0;
    busy             = '0;
    c1_alloc         = '0;
    c2_alloc         = '0;
    c2_alloc_d1      = 1'b0;
    c1_alloc_d2      = 1'b0;
  endtask

  task automatic apply_reset();
    repeat (10) tick();
    rst_n = 1'b1;
    tick();
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================
  task automatic sys_reset_release();
    int n;
    check_value("o_rst.sys", o_rst.sys, 1'b0);
    // loader reset follows vcore
    pwr_vcore_ok = 1'b0;
    settle();
    check_value("o_obl_rst_n", o_obl_rst_n, 1'b0);
    tick();
    pwr_vcore_ok   = 1'b1;
    hsi_rdy        = 1'b1;
    flash_power_ok = 1'b1;
    wait_for("o_rst.sys high", SEL_SYS_RST, 1'b1, 20, n);
    check_value("sys release cycles", n, SYS_RELEASE);
    check_value("o_obl_rst_n", o_obl_rst_n, 1'b1);
    check_value("o_rst.d3_bus", o_rst.d3_bus, 1'b1);
    // pin low asserts on the next edge
    nrst_pin = 1'b0;
    wait_for("o_rst.sys low", SEL_SYS_RST, 1'b0, 5, n);
    check_value("sys assert cycles", n, 1);
    check_value("o_rst.d3_bus", o_rst.d3_bus, 1'b0);
    nrst_pin = 1'b1;
    wait_for("o_rst.sys high", SEL_SYS_RST, 1'b1, 20, n);
    check_value("sys release cycles", n, SYS_RELEASE);
  endtask

  task automatic domain_stretch();
    int n;
    pwr_d2_ok = 1'b1;
    wait_for("o_rst.d2 high", SEL_D2_RST, 1'b1, 40, n);
    check_value("d2 stretch cycles", n, D2_STRETCH + 1);
    check_value("o_rst.d2_bus", o_rst.d2_bus, 1'b1);
    check_value("o_rst.cpu2", o_rst.cpu2, 1'b1);
    check_value("o_rst.d1_bus", o_rst.d1_bus, 1'b0);
    // flash power is off on the edge where the d1 count completes
    pwr_d1_ok = 1'b1;
    repeat (D1_STRETCH) tick();
    flash_power_ok = 1'b0;
    tick();
    check_value("o_rst.d1", o_rst.d1, 1'b0);
    flash_power_ok = 1'b1;
    wait_for("o_rst.d1 high", SEL_D1_RST, 1'b1, 5, n);
    check_value("d1 release cycles", n, 1);
    // restart from the pin since the flash dip also reaches the sys release
    nrst_pin = 1'b0;
    wait_for("o_rst.sys low", SEL_SYS_RST, 1'b0, 5, n);
    nrst_pin = 1'b1;
    wait_for("o_rst.sys high", SEL_SYS_RST, 1'b1, 20, n);
    wait_for("o_rst.d1 high", SEL_D1_RST, 1'b1, 40, n);
    wait_for("o_rst.d2 high", SEL_D2_RST, 1'b1, 40, n);
  endtask

  task automatic derived_resets();
    wwdg1_rst = 1'b1;
    settle();
    check_value("o_rst.cpu1", o_rst.cpu1, 1'b0);
    check_value("o_rst.d1_bus", o_rst.d1_bus, 1'b1);
    check_value("o_rst.cpu2", o_rst.cpu2, 1'b1);
    check_value("o_nrst_out", o_nrst_out, 1'b0);
    tick();
    ww1rsc = 1'b1;
    settle();
    check_value("o_nrst_out", o_nrst_out, 1'b1);
    tick();
    wwdg1_rst = 1'b0;
    settle();
    check_value("o_nrst_out", o_nrst_out, 1'b0);
    check_value("o_rst.cpu1", o_rst.cpu1, 1'b1);
    tick();
    ww1rsc = 1'b0;
  endtask

  task automatic clock_on_delay();
    int n;
    nrst_pin = 1'b0;
    wait_for("o_rst.sys low", SEL_SYS_RST, 1'b0, 5, n);
    // enable drops one edge after the reset
    tick();
    check_value("o_clk_en.sys", o_clk_en.sys, 1'b0);
    nrst_pin = 1'b1;
    wait_for("o_rst.sys high", SEL_SYS_RST, 1'b1, 20, n);
    check_value("o_clk_en.sys", o_clk_en.sys, 1'b0);
    wait_for("o_clk_en.sys high", SEL_SYS_EN, 1'b1, 30, n);
    check_value("clock-on delay cycles", n, CLK_DELAY);
    // bypass, enable follows the reset level
    arcg_on  = 1'b0;
    nrst_pin = 1'b0;
    wait_for("o_rst.sys low", SEL_SYS_RST, 1'b0, 5, n);
    check_value("o_clk_en.sys", o_clk_en.sys, 1'b0);
    nrst_pin = 1'b1;
    wait_for("o_rst.sys high", SEL_SYS_RST, 1'b1, 20, n);
    check_value("o_clk_en.sys", o_clk_en.sys, 1'b1);
    arcg_on = 1'b1;
    wait_for("o_rst.d1 high", SEL_D1_RST, 1'b1, 40, n);
    wait_for("o_rst.d2 high", SEL_D2_RST, 1'b1, 40, n);
  endtask

  task automatic stop_request();
    int n;
    pm.c1_deepsleep = 1'b1;
    pm.c2_deepsleep = 1'b1;
    d3_deepsleep    = 1'b1;
    busy.flash      = 1'b1;
    repeat (3) begin
      tick();
      check_value("o_d1_req", o_d1_req, 1'b0);
      check_value("o_d3_req", o_d3_req, 1'b0);
    end
    // d2 is idle, so its request is already up
    check_value("o_d2_req", o_d2_req, 1'b1);
    check_value("o_clk_en.d2_bus", o_clk_en.d2_bus, 1'b0);
    busy.flash = 1'b0;
    wait_for("o_d1_req high", SEL_D1_REQ, 1'b1, 10, n);
    check_value("d1 request set cycles", n, 1);
    check_value("o_d3_req", o_d3_req, 1'b1);
    check_value("o_clk_en.d1_bus", o_clk_en.d1_bus, 1'b0);
    check_value("o_clk_en.axi", o_clk_en.axi, 1'b0);
    check_value("o_clk_en.ahb3", o_clk_en.ahb3, 1'b0);
    check_value("o_clk_en.apb3", o_clk_en.apb3, 1'b0);
    // system stop takes d3 down as well
    check_value("o_clk_en.sys", o_clk_en.sys, 1'b0);
    check_value("o_clk_en.d3_bus", o_clk_en.d3_bus, 1'b0);
    check_value("o_clk_en.ahb4", o_clk_en.ahb4, 1'b0);
    check_value("o_clk_en.apb4", o_clk_en.apb4, 1'b0);
    // set still holds while c1 stays in deep sleep
    d1_wkup = 1'b1;
    d3_wkup = 1'b1;
    tick();
    check_value("o_d1_req", o_d1_req, 1'b1);
    check_value("o_d3_req", o_d3_req, 1'b1);
    pm.c1_deepsleep = 1'b0;
    wait_for("o_d1_req low", SEL_D1_REQ, 1'b0, 10, n);
    check_value("d1 request clear cycles", n, 1);
    check_value("o_d3_req", o_d3_req, 1'b0);
    check_value("o_clk_en.ahb4", o_clk_en.ahb4, 1'b1);
    d1_wkup         = 1'b0;
    d3_wkup         = 1'b0;
    d3_deepsleep    = 1'b0;
    pm.c2_deepsleep = 1'b0;
    d2_wkup         = 1'b1;
    wait_for("o_d2_req low", SEL_D2_REQ, 1'b0, 10, n);
    check_value("d2 request clear cycles", n, 1);
    d2_wkup = 1'b0;
  endtask

  task automatic sleep_bridges();
    rcc_alloc_t c1_pat [4];
    rcc_alloc_t c2_pat [4];
    rcc_busy_t  busy_pat [4];
    logic       exp_apb1;
    logic       exp_apb2;
    logic       exp_ahb1;
    logic       exp_ahb2;
    // alloc bits: ahb1 ahb2 ahb3 apb1 apb2 apb3
    c1_pat[0]   = 6'b111111;
    c2_pat[0]   = 6'b000000;
    busy_pat[0] = '0;
    c1_pat[1]   = 6'b000000;
    c2_pat[1]   = 6'b000100;
    busy_pat[1] = '0;
    c1_pat[2]   = 6'b110000;
    c2_pat[2]   = 6'b010000;
    busy_pat[2] = 10'b0000001000;
    c1_pat[3]   = 6'b000000;
    c2_pat[3]   = 6'b001001;
    busy_pat[3] = 10'b0001000000;
    pm.c2_sleep = 1'b1;
    for (int i = 0; i < 4; i++) begin
      tick();
      c1_alloc = c1_pat[i];
      c2_alloc = c2_pat[i];
      busy     = busy_pat[i];
      settle();
      // c2 sleeps, so a d2 bridge runs for its allocation or its own traffic
      exp_apb1 = c2_pat[i].apb1 || busy_pat[i].apb1_d2;
      exp_apb2 = c2_pat[i].apb2 || busy_pat[i].apb2_d2;
      exp_ahb1 = c2_pat[i].ahb1 || busy_pat[i].ahb1_d2 || exp_apb1 || exp_apb2;
      exp_ahb2 = c2_pat[i].ahb2 || busy_pat[i].ahb2_d2;
      check_value("o_clk_en.apb1", o_clk_en.apb1, exp_apb1);
      check_value("o_clk_en.apb2", o_clk_en.apb2, exp_apb2);
      check_value("o_clk_en.ahb1", o_clk_en.ahb1, exp_ahb1);
      check_value("o_clk_en.ahb2", o_clk_en.ahb2, exp_ahb2);
      check_value("o_clk_en.axi", o_clk_en.axi, 1'b1);
    end
    // cpu clocks follow their own sleep state
    check_value("o_clk_en.c1", o_clk_en.c1, 1'b1);
    check_value("o_clk_en.c2", o_clk_en.c2, 1'b0);
    check_value("o_clk_en.d2_bus", o_clk_en.d2_bus, 1'b1);
    tick();
    pm   = '0;
    busy = '0;
  endtask

  // ====================================================================
  // main sequence
  // ====================================================================
  initial begin
    drive_defaults();
    apply_reset();
    sys_reset_release();
    domain_stretch();
    derived_resets();
    clock_on_delay();
    stop_request();
    sleep_bridges();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: rcc_ctrl_top.f
verilog/rcc_pkg.sv
verilog/rcc_sys_rst_seq.sv
verilog/rcc_domain_rst_seq.sv
verilog/rcc_rst_clk_gate.sv
verilog/rcc_stop_req.sv
verilog/rcc_clk_en_ctrl.sv
verilog/rcc_ctrl_top.sv
bench/rcc_ctrl_tb.sv

// File: verilog/rcc_clk_en_ctrl.sv
`timescale 1ns/1ps

module rcc_clk_en_ctrl (
  input  rcc_pkg::rcc_cpu_pm_t i_pm,
  input  rcc_pkg::rcc_busy_t   i_busy,
  input  rcc_pkg::rcc_alloc_t  i_c1_alloc,
  input  rcc_pkg::rcc_alloc_t  i_c2_alloc,
  input  logic                i_stop_d1,
  input  logic                i_stop_d2,
  input  logic                i_stop_sys,
  input  logic                i_arcg_en_sys,
  input  logic                i_arcg_en_d1,
  input  logic                i_arcg_en_d2,
  input  logic                i_arcg_en_c1,
  input  logic                i_arcg_en_c2,
  output rcc_pkg::rcc_clk_en_t o_clk_en
);

  logic c1_awake;
  logic c2_awake;
  logic c1_sleep_mode;
  logic c2_sleep_mode;

  // bridge stays clocked for its owner, for a sleeping user, or while busy
  function automatic logic bridge_on(input logic owner_awake, input logic c1_use,
                                     input logic c2_use, input logic busy);
    bridge_on = owner_awake || (c1_sleep_mode && c1_use) || (c2_sleep_mode && c2_use) ||
                busy;
  endfunction

  assign c1_awake      = !i_pm.c1_sleep && !i_pm.c1_deepsleep;
  assign c2_awake      = !i_pm.c2_sleep && !i_pm.c2_deepsleep;
  assign c1_sleep_mode = i_pm.c1_sleep && !i_pm.c1_deepsleep;
  assign c2_sleep_mode = i_pm.c2_sleep && !i_pm.c2_deepsleep;

  // ====================================================================
  // cpu and domain bus enables
  // ====================================================================
  assign o_clk_en.sys    = !i_stop_sys && i_arcg_en_sys;
  assign o_clk_en.c1     = c1_awake && i_arcg_en_c1;
  assign o_clk_en.c2     = c2_awake && i_arcg_en_c2;
  assign o_clk_en.d1_bus = !i_stop_d1 && i_arcg_en_d1;
  assign o_clk_en.d2_bus = !i_stop_d2 && i_arcg_en_d2;
  assign o_clk_en.d3_bus = o_clk_en.sys;

  // ====================================================================
  // bridge enables
  // ====================================================================
  // axi only serves c1
  assign o_clk_en.axi  = c1_awake || i_busy.axi_d1;

  // d1 bridges, owned by c1
  assign o_clk_en.apb3 = bridge_on(c1_awake, i_c1_alloc.apb3, i_c2_alloc.apb3,
                                   i_busy.apb3_d1);
  assign o_clk_en.ahb3 = bridge_on(c1_awake, i_c1_alloc.ahb3, i_c2_alloc.ahb3,
                                   i_busy.ahb3_d1) || o_clk_en.apb3 || i_busy.flash;

  // d2 bridges, owned by c2
  assign o_clk_en.apb1 = bridge_on(c2_awake, i_c1_alloc.apb1, i_c2_alloc.apb1,
                                   i_busy.apb1_d2);
  assign o_clk_en.apb2 = bridge_on(c2_awake, i_c1_alloc.apb2, i_c2_alloc.apb2,
                                   i_busy.apb2_d2);
  // apb1 and apb2 hang off ahb1
  assign o_clk_en.ahb1 = bridge_on(c2_awake, i_c1_alloc.ahb1, i_c2_alloc.ahb1,
                                   i_busy.ahb1_d2) || o_clk_en.apb1 || o_clk_en.apb2;
  assign o_clk_en.ahb2 = bridge_on(c2_awake, i_c1_alloc.ahb2, i_c2_alloc.ahb2,
                                   i_busy.ahb2_d2);

  // d3 runs until system stop
  assign o_clk_en.ahb4 = !i_stop_sys;
  assign o_clk_en.apb4 = !i_stop_sys;

endmodule

// File: verilog/rcc_ctrl_top.sv
`timescale 1ns/1ps

module rcc_ctrl_top (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  // reset sources
  input  logic                 i_nrst_pin,
  input  logic                 i_pwr_por_rst,
  input  logic                 i_pwr_bor_rst,
  input  logic                 i_pwr_vcore_ok,
  input  logic                 i_iwdg1_rst,
  input  logic                 i_iwdg2_rst,
  input  logic                 i_wwdg1_rst,
  input  logic                 i_wwdg2_rst,
  input  logic                 i_ww1rsc,
  input  logic                 i_ww2rsc,
  input  logic [1:0]           i_lpwr_rst,
  input  logic [1:0]           i_sft_rst,
  // flash and oscillator status
  input  logic                 i_flash_obl_reload,
  input  logic                 i_obl_done,
  input  logic                 i_flash_power_ok,
  input  logic                 i_hsi_rdy,
  // power controller
  input  logic                 i_pwr_d1_ok,
  input  logic                 i_pwr_d2_ok,
  input  logic                 i_d3_deepsleep,
  input  logic                 i_d1_wkup,
  input  logic                 i_d2_wkup,
  input  logic                 i_d3_wkup,
  // cpu state and bus status
  input  logic                 i_arcg_on,
  input  rcc_pkg::rcc_cpu_pm_t i_pm,
  input  rcc_pkg::rcc_busy_t   i_busy,
  input  rcc_pkg::rcc_alloc_t  i_c1_alloc,
  input  rcc_pkg::rcc_alloc_t  i_c2_alloc,
  input  logic                 i_c2_alloc_d1,
  input  logic                 i_c1_alloc_d2,
  output rcc_pkg::rcc_rst_t    o_rst,
  output rcc_pkg::rcc_clk_en_t o_clk_en,
  output logic                 o_d1_req,
  output logic                 o_d2_req,
  output logic                 o_d3_req,
  output logic                 o_obl_rst_n,
  output logic                 o_nrst_out
);

  import rcc_pkg::*;

  logic       sys_rst_n;
  logic       d1_rst_n;
  logic       d2_rst_n;
  logic [3:0] wdg_rst;
  rcc_rst_t   rst;
  // order: cpu2, cpu1, d2, d1, sys
  logic [4:0] gate_src_rst_n;
  logic [4:0] gate_clk_en;

  // window watchdogs reach the pad only when enabled
  assign wdg_rst = {i_iwdg1_rst, i_iwdg2_rst, i_wwdg1_rst && i_ww1rsc, i_wwdg2_rst && i_ww2rsc};

  // ====================================================================
  // reset sequencing
  // ====================================================================
  rcc_sys_rst_seq u_sys_rst_seq (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_nrst_pin         (i_nrst_pin),
    .i_pwr_por_rst      (i_pwr_por_rst),
    .i_pwr_bor_rst      (i_pwr_bor_rst),
    .i_pwr_vcore_ok     (i_pwr_vcore_ok),
    .i_flash_obl_reload (i_flash_obl_reload),
    .i_obl_done         (i_obl_done),
    .i_hsi_rdy          (i_hsi_rdy),
    .i_flash_power_ok   (i_flash_power_ok),
    .i_wdg_rst          (wdg_rst),
    .i_lpwr_rst         (i_lpwr_rst),
    .i_sft_rst          (i_sft_rst),
    .o_sys_rst_n        (sys_rst_n),
    .o_obl_rst_n        (o_obl_rst_n),
    .o_nrst_out         (o_nrst_out)
  );

  rcc_domain_rst_seq #(
    .DURATION   (D1_RST_DURATION),
    .WAIT_FLASH (1'b1)
  ) u_d1_rst_seq (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_sys_rst_n      (sys_rst_n),
    .i_pwr_ok         (i_pwr_d1_ok),
    .i_flash_power_ok (i_flash_power_ok),
    .o_dom_rst_n      (d1_rst_n)
  );

  rcc_domain_rst_seq #(
    .DURATION   (D2_RST_DURATION),
    .WAIT_FLASH (1'b0)
  ) u_d2_rst_seq (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_sys_rst_n      (sys_rst_n),
    .i_pwr_ok         (i_pwr_d2_ok),
    .i_flash_power_ok (i_flash_power_ok),
    .o_dom_rst_n      (d2_rst_n)
  );

  // derived cpu and bus resets
  assign rst.sys    = sys_rst_n;
  assign rst.d1     = d1_rst_n;
  assign rst.d2     = d2_rst_n;
  assign rst.cpu1   = sys_rst_n && d1_rst_n && !i_wwdg1_rst;
  assign rst.cpu2   = sys_rst_n && d2_rst_n && !i_wwdg2_rst;
  assign rst.d1_bus = sys_rst_n && d1_rst_n;
  assign rst.d2_bus = sys_rst_n && d2_rst_n;
  assign rst.d3_bus = sys_rst_n;
  assign o_rst      = rst;

  // ====================================================================
  // clock-on delay after reset release
  // ====================================================================
  assign gate_src_rst_n = {rst.cpu2, rst.cpu1, rst.d2, rst.d1, rst.sys};

  for (genvar g = 0; g < 5; g++) begin : g_clk_gate
    rcc_rst_clk_gate #(
      .DELAY (CLK_ON_DELAY)
    ) u_rst_clk_gate (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_src_rst_n (gate_src_rst_n[g]),
      .i_arcg_on   (i_arcg_on),
      .o_clk_en    (gate_clk_en[g])
    );
  end

  // ====================================================================
  // stop requests and clock enables
  // ====================================================================
  rcc_stop_req u_stop_req (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_sys_rst_n    (sys_rst_n),
    .i_pm           (i_pm),
    .i_busy         (i_busy),
    .i_c2_alloc_d1  (i_c2_alloc_d1),
    .i_c1_alloc_d2  (i_c1_alloc_d2),
    .i_d3_deepsleep (i_d3_deepsleep),
    .i_d1_wkup      (i_d1_wkup),
    .i_d2_wkup      (i_d2_wkup),
    .i_d3_wkup      (i_d3_wkup),
    .o_d1_req       (o_d1_req),
    .o_d2_req       (o_d2_req),
    .o_d3_req       (o_d3_req)
  );

  rcc_clk_en_ctrl u_clk_en_ctrl (
    .i_pm          (i_pm),
    .i_busy        (i_busy),
    .i_c1_alloc    (i_c1_alloc),
    .i_c2_alloc    (i_c2_alloc),
    .i_stop_d1     (o_d1_req),
    .i_stop_d2     (o_d2_req),
    .i_stop_sys    (o_d3_req),
    .i_arcg_en_sys (gate_clk_en[0]),
    .i_arcg_en_d1  (gate_clk_en[1]),
    .i_arcg_en_d2  (gate_clk_en[2]),
    .i_arcg_en_c1  (gate_clk_en[3]),
    .i_arcg_en_c2  (gate_clk_en[4]),
    .o_clk_en      (o_clk_en)
  );

endmodule

// File: verilog/rcc_domain_rst_seq.sv
`timescale 1ns/1ps

module rcc_domain_rst_seq #(
  parameter int DURATION   = rcc_pkg::D1_RST_DURATION,
  parameter bit WAIT_FLASH = 1'b1
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_sys_rst_n,
  input  logic i_pwr_ok,
  input  logic i_flash_power_ok,
  output logic o_dom_rst_n
);

  import rcc_pkg::*;

  rst_cnt_t cnt_q;
  logic     cnt_done;
  logic     flash_ok;

  assign cnt_done = (cnt_q == rst_cnt_t'(DURATION));

  // flash lives in d1 only
  assign flash_ok = WAIT_FLASH ? i_flash_power_ok : 1'b1;

  // ====================================================================
  // stretch counter and release flop
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || !i_sys_rst_n || !i_pwr_ok) begin
      cnt_q       <= '0;
      o_dom_rst_n <= 1'b0;
    end else begin
      if (!cnt_done) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // stays released once set
      if (cnt_done && flash_ok) begin
        o_dom_rst_n <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/rcc_pkg.sv
package rcc_pkg;

  // ====================================================================
  // timing constants
  // ====================================================================
  localparam int D1_RST_DURATION = 10;
  localparam int D2_RST_DURATION = 10;
  localparam int CLK_ON_DELAY    = 8;
  localparam int RST_CNT_W       = 4;
  localparam int CLK_ON_CNT_W    = 4;
  localparam int SYNC_STAGES     = 2;

  typedef logic [RST_CNT_W-1:0]    rst_cnt_t;
  typedef logic [CLK_ON_CNT_W-1:0] clk_on_cnt_t;

  // ====================================================================
  // grouped level signals
  // ====================================================================
  // bridge busy flags, d1 then d2 then d3
  typedef struct packed {
    logic axi_d1;
    logic ahb3_d1;
    logic apb3_d1;
    logic ahb1_d2;
    logic ahb2_d2;
    logic apb1_d2;
    logic apb2_d2;
    logic ahb4_d3;
    logic apb4_d3;
    logic flash;
  } rcc_busy_t;

  // per-bus peripheral allocation of one cpu
  typedef struct packed {
    logic ahb1;
    logic ahb2;
    logic ahb3;
    logic apb1;
    logic apb2;
    logic apb3;
  } rcc_alloc_t;

  typedef struct packed {
    logic c1_sleep;
    logic c1_deepsleep;
    logic c2_sleep;
    logic c2_deepsleep;
  } rcc_cpu_pm_t;

  // all active low
  typedef struct packed {
    logic sys;
    logic d1;
    logic d2;
    logic cpu1;
    logic cpu2;
    logic d1_bus;
    logic d2_bus;
    logic d3_bus;
  } rcc_rst_t;

  typedef struct packed {
    logic sys;
    logic c1;
    logic c2;
    logic d1_bus;
    logic d2_bus;
    logic d3_bus;
    logic axi;
    logic ahb1;
    logic ahb2;
    logic ahb3;
    logic ahb4;
    logic apb1;
    logic apb2;
    logic apb3;
    logic apb4;
  } rcc_clk_en_t;

endpackage

// File: verilog/rcc_rst_clk_gate.sv
`timescale 1ns/1ps

module rcc_rst_clk_gate #(
  parameter int DELAY = rcc_pkg::CLK_ON_DELAY
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_src_rst_n,
  input  logic i_arcg_on,
  output logic o_clk_en
);

  import rcc_pkg::*;

  clk_on_cnt_t cnt_q;
  logic        cnt_done;

  assign cnt_done = (cnt_q == clk_on_cnt_t'(DELAY));

  // counts edges seen with the source out of reset
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || !i_src_rst_n) begin
      cnt_q <= '0;
    end else if (!cnt_done) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // bypass follows the reset level directly
  assign o_clk_en = i_arcg_on ? cnt_done : i_src_rst_n;

endmodule

// File: verilog/rcc_stop_req.sv
`timescale 1ns/1ps

module rcc_stop_req (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_sys_rst_n,
  input  rcc_pkg::rcc_cpu_pm_t i_pm,
  input  rcc_pkg::rcc_busy_t   i_busy,
  input  logic                i_c2_alloc_d1,
  input  logic                i_c1_alloc_d2,
  input  logic                i_d3_deepsleep,
  input  logic                i_d1_wkup,
  input  logic                i_d2_wkup,
  input  logic                i_d3_wkup,
  output logic                o_d1_req,
  output logic                o_d2_req,
  output logic                o_d3_req
);

  logic       d1_busy;
  logic       d2_busy;
  logic       d3_busy;
  logic [2:0] req_set;
  logic [2:0] req_wkup;
  logic [2:0] req_q;

  // ====================================================================
  // domain busy
  // ====================================================================
  assign d1_busy = i_busy.axi_d1 || i_busy.ahb3_d1 || i_busy.apb3_d1 || i_busy.flash;
  assign d2_busy = i_busy.ahb1_d2 || i_busy.ahb2_d2 || i_busy.apb1_d2 || i_busy.apb2_d2;
  assign d3_busy = d1_busy || d2_busy || i_busy.ahb4_d3 || i_busy.apb4_d3;

  // c2 only matters in d1 if it owns something there, likewise c1 in d2
  assign req_set[0] = i_pm.c1_deepsleep && (i_pm.c2_deepsleep || !i_c2_alloc_d1) && !d1_busy;
  assign req_set[1] = i_pm.c2_deepsleep && (i_pm.c1_deepsleep || !i_c1_alloc_d2) && !d2_busy;
  assign req_set[2] = i_pm.c1_deepsleep && i_pm.c2_deepsleep && i_d3_deepsleep && !d3_busy;

  assign req_wkup = {i_d3_wkup, i_d2_wkup, i_d1_wkup};

  // ====================================================================
  // request flops, set beats wakeup
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || !i_sys_rst_n) begin
      req_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (req_set[i]) begin
          req_q[i] <= 1'b1;
        end else if (req_wkup[i]) begin
          req_q[i] <= 1'b0;
        end
      end
    end
  end

  assign o_d1_req = req_q[0];
  assign o_d2_req = req_q[1];
  assign o_d3_req = req_q[2];

endmodule

// File: verilog/rcc_sys_rst_seq.sv
`timescale 1ns/1ps

module rcc_sys_rst_seq (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_nrst_pin,
  input  logic       i_pwr_por_rst,
  input  logic       i_pwr_bor_rst,
  input  logic       i_pwr_vcore_ok,
  input  logic       i_flash_obl_reload,
  input  logic       i_obl_done,
  input  logic       i_hsi_rdy,
  input  logic       i_flash_power_ok,
  // iwdg1, iwdg2, qualified wwdg1, qualified wwdg2
  input  logic [3:0] i_wdg_rst,
  input  logic [1:0] i_lpwr_rst,
  input  logic [1:0] i_sft_rst,
  output logic       o_sys_rst_n,
  output logic       o_obl_rst_n,
  output logic       o_nrst_out
);

  import rcc_pkg::*;

  logic                   hw_init_done;
  logic                   obl_rst;
  logic                   rst_assert;
  logic                   rst_release;
  logic [SYNC_STAGES-1:0] sync_q;

  // power good and option bytes loaded
  assign hw_init_done = ~i_pwr_por_rst && i_pwr_vcore_ok && ~i_flash_obl_reload && i_obl_done;
  assign obl_rst      = ~i_obl_done || i_flash_obl_reload;
  assign rst_assert   = ~i_nrst_pin || ~hw_init_done;
  assign rst_release  = i_hsi_rdy && i_flash_power_ok;

  // ====================================================================
  // release path: sync stages then output flop
  // ====================================================================
  always_ff @(posedge i_clk) begin
    if (!i_rst_n || rst_assert) begin
      sync_q      <= '0;
      o_sys_rst_n <= 1'b0;
    end else begin
      sync_q      <= {sync_q[SYNC_STAGES-2:0], rst_release};
      o_sys_rst_n <= sync_q[SYNC_STAGES-1];
    end
  end

  // option byte loader leaves reset once power is up
  assign o_obl_rst_n = ~i_pwr_por_rst && i_pwr_vcore_ok;

  // drive the pad while any source is active
  assign o_nrst_out = obl_rst || i_pwr_por_rst || i_pwr_bor_rst || (|i_wdg_rst) ||
                      (|i_lpwr_rst) || (|i_sft_rst);

endmodule
